// ==== flist.f ====
common/collision_pkg.sv
rtl/pipe_control.sv
sat/box_projector.sv
sat/extent_penetration.sv
rtl/penetration_select.sv
rtl/sat_collision_top.sv
sim/tb_clock_gen.sv
sim/sat_collision_assertions.sv
sim/sat_collision_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = sat_collision_tb
RTL_TOP    = sat_collision_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/sat_collision_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sat_collision_tb;

    localparam int NUM_ROWS = 7;
    localparam int FIRST_RANDOM = 5;
    // About 4 cycles per row, with margin for reset and the burst
    localparam int TIMEOUT_NS = (NUM_ROWS + 10) * 4 * 100;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic                     out_valid;
    logic                     is_collision;
    collision_pkg::axis_t     normal_x;
    collision_pkg::axis_t     normal_y;
    collision_pkg::pen_t      penetration;
    // Box inputs, index 0 for box A and 1 for box B
    collision_pkg::pos_t      px [2];
    collision_pkg::pos_t      py [2];
    collision_pkg::axis_t     ux [2];
    collision_pkg::axis_t     uy [2];
    collision_pkg::axis_t     vx [2];
    collision_pkg::axis_t     vy [2];
    collision_pkg::point_t    kx [2][4];
    collision_pkg::point_t    ky [2][4];
    collision_pkg::half_ext_t hw [2];
    collision_pkg::half_ext_t hh [2];
    string                    names [NUM_ROWS];
    // A pos_x, pos_y, rotated, half width, half height, then the same for B
    int                       geo [NUM_ROWS][10];
    // is_collision, penetration, normal_x, normal_y
    int                       exp_tab [NUM_ROWS][4];
    int                       seed;
    int                       errors;
    int                       tests;

    tb_clock_gen u_clock_gen (.clk(clk));

    sat_collision_top u_dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .box_a_pos_x(px[0]), .box_a_pos_y(py[0]),
        .box_a_u_x(ux[0]), .box_a_u_y(uy[0]), .box_a_v_x(vx[0]), .box_a_v_y(vy[0]),
        .box_a_corner0_x(kx[0][0]), .box_a_corner0_y(ky[0][0]),
        .box_a_corner1_x(kx[0][1]), .box_a_corner1_y(ky[0][1]),
        .box_a_corner2_x(kx[0][2]), .box_a_corner2_y(ky[0][2]),
        .box_a_corner3_x(kx[0][3]), .box_a_corner3_y(ky[0][3]),
        .box_a_half_width(hw[0]), .box_a_half_height(hh[0]),
        .box_b_pos_x(px[1]), .box_b_pos_y(py[1]),
        .box_b_u_x(ux[1]), .box_b_u_y(uy[1]), .box_b_v_x(vx[1]), .box_b_v_y(vy[1]),
        .box_b_corner0_x(kx[1][0]), .box_b_corner0_y(ky[1][0]),
        .box_b_corner1_x(kx[1][1]), .box_b_corner1_y(ky[1][1]),
        .box_b_corner2_x(kx[1][2]), .box_b_corner2_y(ky[1][2]),
        .box_b_corner3_x(kx[1][3]), .box_b_corner3_y(ky[1][3]),
        .box_b_half_width(hw[1]), .box_b_half_height(hh[1]),
        .out_valid(out_valid), .is_collision(is_collision),
        .normal_x(normal_x), .normal_y(normal_y), .penetration(penetration)
    );

    // Corners 0..3 sit at (+w,+h), (-w,+h), (-w,-h), (+w,-h) along u and v.
    // A half extent h is h << 16 in corner scale, so along a Q12 axis it moves h * 16 * axis
    task automatic set_box(input int b, input int x, input int y, input int rot,
                           input int w, input int h);
        int s1;
        int s2;
        px[b] = collision_pkg::pos_t'(x);
        py[b] = collision_pkg::pos_t'(y);
        ux[b] = rot ? 16'sd2896 : 16'sd4096;
        uy[b] = rot ? 16'sd2896 : 16'sd0;
        vx[b] = rot ? -16'sd2896 : 16'sd0;
        vy[b] = rot ? 16'sd2896 : 16'sd4096;
        hw[b] = collision_pkg::half_ext_t'(w);
        hh[b] = collision_pkg::half_ext_t'(h);
        for (int i = 0; i < 4; i++) begin
            s1 = (i == 0 || i == 3) ? 1 : -1;
            s2 = (i < 2) ? 1 : -1;
            kx[b][i] = collision_pkg::point_t'((x >>> 2) + s1 * w * 16 * ux[b]
                                               + s2 * h * 16 * vx[b]);
            ky[b][i] = collision_pkg::point_t'((y >>> 2) + s1 * w * 16 * uy[b]
                                               + s2 * h * 16 * vy[b]);
        end
    endtask

    task automatic load_row(input int r);
        set_box(0, geo[r][0], geo[r][1], geo[r][2], geo[r][3], geo[r][4]);
        set_box(1, geo[r][5], geo[r][6], geo[r][7], geo[r][8], geo[r][9]);
    endtask

    // Expected result for the boxes now on the inputs.
    // Candidates in the order AB u, BA u, AB v, BA v; only a strictly smaller one replaces
    task automatic predict_row(input int r);
        longint p, lo, hi, ext, cand, best;
        int s, f, ax, ay, sgn;
        for (int k = 0; k < 4; k++) begin
            s = k % 2;
            f = 1 - s;
            ax = (k < 2) ? ux[f] : vx[f];
            ay = (k < 2) ? uy[f] : vy[f];
            ext = longint'((k < 2) ? hw[f] : hh[f]) <<< 16;
            for (int i = 0; i < 4; i++) begin
                p = ((longint'(kx[s][i]) - longint'(px[f] >>> 2)) * ax
                     + (longint'(ky[s][i]) - longint'(py[f] >>> 2)) * ay) >>> 12;
                lo = (i == 0 || p < lo) ? p : lo;
                hi = (i == 0 || p > hi) ? p : hi;
            end
            // Max side only wins when strictly smaller, and keeps the axis direction
            sgn = (hi + ext < ext - lo) ? 1 : -1;
            cand = (sgn > 0) ? hi + ext : ext - lo;
            if (k == 0 || cand < best) begin
                best = cand;
                exp_tab[r][2] = sgn * ax;
                exp_tab[r][3] = sgn * ay;
            end
        end
        exp_tab[r][0] = (best >= 0) ? 1 : 0;
        exp_tab[r][1] = int'(best);
    endtask

    task automatic check_row(input string name, input int r, input bit exp_valid);
        bit ok;
        ok = 1'b1;
        tests++;
        assert (out_valid == exp_valid) else begin
            $display("CHECK FAILED %s expected out_valid=%0b actual out_valid=%0b",
                     name, exp_valid, out_valid);
            ok = 1'b0;
        end
        assert (is_collision == exp_tab[r][0] && penetration == exp_tab[r][1]
                && normal_x == exp_tab[r][2] && normal_y == exp_tab[r][3]) else begin
            $display("CHECK FAILED %s expected col=%0d pen=%0d normal=(%0d,%0d) %s",
                     name, exp_tab[r][0], exp_tab[r][1], exp_tab[r][2], exp_tab[r][3],
                     $sformatf("actual col=%0d pen=%0d normal=(%0d,%0d)",
                               is_collision, penetration, normal_x, normal_y));
            ok = 1'b0;
        end
        errors += ok ? 0 : 1;
        $display("%s: %s", name, ok ? "passed" : "failed");
    endtask

    // One strobe, wait for the result, then check that it holds while idle
    task automatic run_row(input int r);
        int lat;
        load_row(r);
        if (r >= FIRST_RANDOM) begin
            predict_row(r);
        end
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        lat = 1;
        while (!out_valid) begin
            @(negedge clk);
            lat++;
        end
        assert (lat == 3) else begin
            $display("CHECK FAILED %s_latency expected 3 cycles actual %0d cycles",
                     names[r], lat);
            errors++;
        end
        check_row(names[r], r, 1'b1);
        @(negedge clk);
        check_row({names[r], "_hold"}, r, 1'b0);
    endtask

    // Three strobes back to back, sharing axes and half extents
    task automatic run_burst();
        int seq [3];
        seq = '{0, 1, 0};
        for (int k = 0; k < 3; k++) begin
            load_row(seq[k]);
            in_valid = 1'b1;
            @(negedge clk);
        end
        in_valid = 1'b0;
        for (int k = 0; k < 3; k++) begin
            check_row({"burst_", names[seq[k]]}, seq[k], 1'b1);
            @(negedge clk);
        end
        check_row("burst_hold", 0, 1'b0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed = 2;
        errors = 0;
        tests = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        names = '{"overlap_aligned", "apart_along_u", "apart_along_v", "rotated_b",
                  "ties_same_box", "random_0", "random_1"};
        geo[0] = '{0, 0, 0, 4, 2, 1572864, 262144, 0, 3, 2};
        geo[1] = '{0, 0, 0, 4, 2, 2621440, 0, 0, 3, 2};
        geo[2] = '{0, 0, 0, 2, 2, 0, -2097152, 0, 2, 3};
        geo[3] = '{0, 0, 0, 4, 4, 1310720, 0, 1, 2, 2};
        geo[4] = '{0, 0, 0, 2, 2, 0, 0, 0, 2, 2};
        exp_tab[0] = '{1, 65536, 4096, 0};
        exp_tab[1] = '{0, -196608, 4096, 0};
        exp_tab[2] = '{0, -196608, 0, -4096};
        exp_tab[3] = '{1, 119808, -4096, 0};
        exp_tab[4] = '{1, 262144, -4096, 0};
        // Rotated B at a random offset of up to half a million corner units
        for (int r = FIRST_RANDOM; r < NUM_ROWS; r++) begin
            geo[r] = '{0, 0, 0, 3, 3, 0, 0, 1, 2, 3};
            geo[r][5] = $random(seed) % 2097152;
            geo[r][6] = $random(seed) % 2097152;
        end
        load_row(0);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        tests++;
        assert (!out_valid && is_collision && penetration == 0 && normal_x == 0
                && normal_y == 0) else begin
            $display("CHECK FAILED reset_state expected %s actual %s",
                     "out_valid=0 col=1 pen=0 normal=(0,0)",
                     $sformatf("out_valid=%0b col=%0d pen=%0d normal=(%0d,%0d)",
                               out_valid, is_collision, penetration, normal_x, normal_y));
            errors++;
        end
        $display("reset_state: %s", (errors == 0) ? "passed" : "failed");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        run_burst();
        $display("Summary: %0d tests, %0d failed checks", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/sat_collision_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module sat_collision_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);

    // Every strobe comes out exactly PIPE_DEPTH cycles later, and nothing else does
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, collision_pkg::PIPE_DEPTH))
        else $error("out_valid does not follow in_valid by the pipeline depth");

    a_reset_clear: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid is high in the cycle after a reset cycle");

endmodule

bind sat_collision_top sat_collision_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid)
);

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period, starting low
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== rtl/sat_collision_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sat_collision_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  collision_pkg::pos_t      box_a_pos_x, box_a_pos_y,
    input  collision_pkg::axis_t     box_a_u_x, box_a_u_y, box_a_v_x, box_a_v_y,
    input  collision_pkg::point_t    box_a_corner0_x, box_a_corner0_y,
    input  collision_pkg::point_t    box_a_corner1_x, box_a_corner1_y,
    input  collision_pkg::point_t    box_a_corner2_x, box_a_corner2_y,
    input  collision_pkg::point_t    box_a_corner3_x, box_a_corner3_y,
    input  collision_pkg::half_ext_t box_a_half_width, box_a_half_height,
    input  collision_pkg::pos_t      box_b_pos_x, box_b_pos_y,
    input  collision_pkg::axis_t     box_b_u_x, box_b_u_y, box_b_v_x, box_b_v_y,
    input  collision_pkg::point_t    box_b_corner0_x, box_b_corner0_y,
    input  collision_pkg::point_t    box_b_corner1_x, box_b_corner1_y,
    input  collision_pkg::point_t    box_b_corner2_x, box_b_corner2_y,
    input  collision_pkg::point_t    box_b_corner3_x, box_b_corner3_y,
    input  collision_pkg::half_ext_t box_b_half_width, box_b_half_height,
    output logic                     out_valid,
    output logic                     is_collision,
    output collision_pkg::axis_t     normal_x,
    output collision_pkg::axis_t     normal_y,
    output collision_pkg::pen_t      penetration
);

    logic                 s1_load, s2_load, s3_load;
    collision_pkg::proj_t ab_pu0, ab_pu1, ab_pu2, ab_pu3;
    collision_pkg::proj_t ab_pv0, ab_pv1, ab_pv2, ab_pv3;
    collision_pkg::proj_t ba_pu0, ba_pu1, ba_pu2, ba_pu3;
    collision_pkg::proj_t ba_pv0, ba_pv1, ba_pv2, ba_pv3;
    collision_pkg::pen_t  ab_min_u, ab_max_u, ab_min_v, ab_max_v;
    collision_pkg::pen_t  ba_min_u, ba_max_u, ba_min_v, ba_max_v;

    pipe_control u_pipe_control (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .s1_load(s1_load), .s2_load(s2_load), .s3_load(s3_load), .out_valid(out_valid)
    );

    // Corners of A in the frame of B
    box_projector u_proj_a_on_b (
        .clk(clk), .rst_n(rst_n), .load(s1_load),
        .corner0_x(box_a_corner0_x), .corner0_y(box_a_corner0_y),
        .corner1_x(box_a_corner1_x), .corner1_y(box_a_corner1_y),
        .corner2_x(box_a_corner2_x), .corner2_y(box_a_corner2_y),
        .corner3_x(box_a_corner3_x), .corner3_y(box_a_corner3_y),
        .center_x(box_b_pos_x), .center_y(box_b_pos_y),
        .u_x(box_b_u_x), .u_y(box_b_u_y), .v_x(box_b_v_x), .v_y(box_b_v_y),
        .proj_u0(ab_pu0), .proj_u1(ab_pu1), .proj_u2(ab_pu2), .proj_u3(ab_pu3),
        .proj_v0(ab_pv0), .proj_v1(ab_pv1), .proj_v2(ab_pv2), .proj_v3(ab_pv3)
    );

    // Corners of B in the frame of A
    box_projector u_proj_b_on_a (
        .clk(clk), .rst_n(rst_n), .load(s1_load),
        .corner0_x(box_b_corner0_x), .corner0_y(box_b_corner0_y),
        .corner1_x(box_b_corner1_x), .corner1_y(box_b_corner1_y),
        .corner2_x(box_b_corner2_x), .corner2_y(box_b_corner2_y),
        .corner3_x(box_b_corner3_x), .corner3_y(box_b_corner3_y),
        .center_x(box_a_pos_x), .center_y(box_a_pos_y),
        .u_x(box_a_u_x), .u_y(box_a_u_y), .v_x(box_a_v_x), .v_y(box_a_v_y),
        .proj_u0(ba_pu0), .proj_u1(ba_pu1), .proj_u2(ba_pu2), .proj_u3(ba_pu3),
        .proj_v0(ba_pv0), .proj_v1(ba_pv1), .proj_v2(ba_pv2), .proj_v3(ba_pv3)
    );

    extent_penetration u_ext_a_on_b (
        .clk(clk), .rst_n(rst_n), .load(s2_load),
        .proj_u0(ab_pu0), .proj_u1(ab_pu1), .proj_u2(ab_pu2), .proj_u3(ab_pu3),
        .proj_v0(ab_pv0), .proj_v1(ab_pv1), .proj_v2(ab_pv2), .proj_v3(ab_pv3),
        .half_width(box_b_half_width), .half_height(box_b_half_height),
        .pen_min_u(ab_min_u), .pen_max_u(ab_max_u),
        .pen_min_v(ab_min_v), .pen_max_v(ab_max_v)
    );

    extent_penetration u_ext_b_on_a (
        .clk(clk), .rst_n(rst_n), .load(s2_load),
        .proj_u0(ba_pu0), .proj_u1(ba_pu1), .proj_u2(ba_pu2), .proj_u3(ba_pu3),
        .proj_v0(ba_pv0), .proj_v1(ba_pv1), .proj_v2(ba_pv2), .proj_v3(ba_pv3),
        .half_width(box_a_half_width), .half_height(box_a_half_height),
        .pen_min_u(ba_min_u), .pen_max_u(ba_max_u),
        .pen_min_v(ba_min_v), .pen_max_v(ba_max_v)
    );

    penetration_select u_penetration_select (
        .clk(clk), .rst_n(rst_n), .load(s3_load),
        .ab_pen_min_u(ab_min_u), .ab_pen_max_u(ab_max_u),
        .ab_pen_min_v(ab_min_v), .ab_pen_max_v(ab_max_v),
        .ba_pen_min_u(ba_min_u), .ba_pen_max_u(ba_max_u),
        .ba_pen_min_v(ba_min_v), .ba_pen_max_v(ba_max_v),
        .b_u_x(box_b_u_x), .b_u_y(box_b_u_y), .b_v_x(box_b_v_x), .b_v_y(box_b_v_y),
        .a_u_x(box_a_u_x), .a_u_y(box_a_u_y), .a_v_x(box_a_v_x), .a_v_y(box_a_v_y),
        .is_collision(is_collision),
        .normal_x(normal_x), .normal_y(normal_y),
        .penetration(penetration)
    );

endmodule

`default_nettype wire

// ==== rtl/penetration_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module penetration_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  collision_pkg::pen_t  ab_pen_min_u, ab_pen_max_u,
    input  collision_pkg::pen_t  ab_pen_min_v, ab_pen_max_v,
    input  collision_pkg::pen_t  ba_pen_min_u, ba_pen_max_u,
    input  collision_pkg::pen_t  ba_pen_min_v, ba_pen_max_v,
    input  collision_pkg::axis_t b_u_x, b_u_y, b_v_x, b_v_y,
    input  collision_pkg::axis_t a_u_x, a_u_y, a_v_x, a_v_y,
    output logic                 is_collision,
    output collision_pkg::axis_t normal_x,
    output collision_pkg::axis_t normal_y,
    output collision_pkg::pen_t  penetration
);

    // Per test and axis: penetration and normal after the min/max pick
    collision_pkg::pen_t  ab_u_pen, ab_v_pen, ba_u_pen, ba_v_pen;
    collision_pkg::axis_t ab_u_nx, ab_u_ny, ab_v_nx, ab_v_ny;
    collision_pkg::axis_t ba_u_nx, ba_u_ny, ba_v_nx, ba_v_ny;
    collision_pkg::pen_t  u_pen, v_pen, best_pen;
    collision_pkg::axis_t u_nx, u_ny, v_nx, v_ny, best_nx, best_ny;

    // Axes come straight from the ports, so the caller holds them until the result is out
    always_comb begin
        // Min side wins ties and points the normal against the axis
        ab_u_pen = (ab_pen_max_u < ab_pen_min_u) ? ab_pen_max_u : ab_pen_min_u;
        ab_u_nx  = (ab_pen_max_u < ab_pen_min_u) ? b_u_x : -b_u_x;
        ab_u_ny  = (ab_pen_max_u < ab_pen_min_u) ? b_u_y : -b_u_y;
        ab_v_pen = (ab_pen_max_v < ab_pen_min_v) ? ab_pen_max_v : ab_pen_min_v;
        ab_v_nx  = (ab_pen_max_v < ab_pen_min_v) ? b_v_x : -b_v_x;
        ab_v_ny  = (ab_pen_max_v < ab_pen_min_v) ? b_v_y : -b_v_y;
        ba_u_pen = (ba_pen_max_u < ba_pen_min_u) ? ba_pen_max_u : ba_pen_min_u;
        ba_u_nx  = (ba_pen_max_u < ba_pen_min_u) ? a_u_x : -a_u_x;
        ba_u_ny  = (ba_pen_max_u < ba_pen_min_u) ? a_u_y : -a_u_y;
        ba_v_pen = (ba_pen_max_v < ba_pen_min_v) ? ba_pen_max_v : ba_pen_min_v;
        ba_v_nx  = (ba_pen_max_v < ba_pen_min_v) ? a_v_x : -a_v_x;
        ba_v_ny  = (ba_pen_max_v < ba_pen_min_v) ? a_v_y : -a_v_y;

        // A onto B unless B onto A is strictly smaller
        u_pen = (ba_u_pen < ab_u_pen) ? ba_u_pen : ab_u_pen;
        u_nx  = (ba_u_pen < ab_u_pen) ? ba_u_nx : ab_u_nx;
        u_ny  = (ba_u_pen < ab_u_pen) ? ba_u_ny : ab_u_ny;
        v_pen = (ba_v_pen < ab_v_pen) ? ba_v_pen : ab_v_pen;
        v_nx  = (ba_v_pen < ab_v_pen) ? ba_v_nx : ab_v_nx;
        v_ny  = (ba_v_pen < ab_v_pen) ? ba_v_ny : ab_v_ny;

        // u unless v is strictly smaller
        best_pen = (v_pen < u_pen) ? v_pen : u_pen;
        best_nx  = (v_pen < u_pen) ? v_nx : u_nx;
        best_ny  = (v_pen < u_pen) ? v_ny : u_ny;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // A zero penetration is not negative, so it counts as a collision
            is_collision <= 1'b1;
            normal_x     <= '0;
            normal_y     <= '0;
            penetration  <= '0;
        end else if (load) begin
            is_collision <= ~best_pen[31];
            normal_x     <= best_nx;
            normal_y     <= best_ny;
            penetration  <= best_pen;
        end
    end

endmodule

`default_nettype wire

// ==== sat/extent_penetration.sv ====
`timescale 1ns/1ps
`default_nettype none

module extent_penetration (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  collision_pkg::proj_t     proj_u0, proj_u1, proj_u2, proj_u3,
    input  collision_pkg::proj_t     proj_v0, proj_v1, proj_v2, proj_v3,
    input  collision_pkg::half_ext_t half_width,
    input  collision_pkg::half_ext_t half_height,
    output collision_pkg::pen_t      pen_min_u,
    output collision_pkg::pen_t      pen_max_u,
    output collision_pkg::pen_t      pen_min_v,
    output collision_pkg::pen_t      pen_max_v
);

    collision_pkg::proj_t min_u;
    collision_pkg::proj_t max_u;
    collision_pkg::proj_t min_v;
    collision_pkg::proj_t max_v;
    collision_pkg::pen_t  ext_w;
    collision_pkg::pen_t  ext_h;

    function automatic collision_pkg::proj_t min2(input collision_pkg::proj_t a,
                                                  input collision_pkg::proj_t b);
        return (b < a) ? b : a;
    endfunction

    function automatic collision_pkg::proj_t max2(input collision_pkg::proj_t a,
                                                  input collision_pkg::proj_t b);
        return (b > a) ? b : a;
    endfunction

    // Pairs 0/1 and 2/3 first, then the two winners
    assign min_u = min2(min2(proj_u0, proj_u1), min2(proj_u2, proj_u3));
    assign max_u = max2(max2(proj_u0, proj_u1), max2(proj_u2, proj_u3));
    assign min_v = min2(min2(proj_v0, proj_v1), min2(proj_v2, proj_v3));
    assign max_v = max2(max2(proj_v0, proj_v1), max2(proj_v2, proj_v3));

    // Half extents in projection scale
    assign ext_w = collision_pkg::pen_t'(half_width) <<< collision_pkg::EXT_SHIFT;
    assign ext_h = collision_pkg::pen_t'(half_height) <<< collision_pkg::EXT_SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pen_min_u <= '0;
            pen_max_u <= '0;
            pen_min_v <= '0;
            pen_max_v <= '0;
        end else if (load) begin
            pen_min_u <= ext_w - collision_pkg::pen_t'(min_u);
            pen_max_u <= collision_pkg::pen_t'(max_u) + ext_w;
            pen_min_v <= ext_h - collision_pkg::pen_t'(min_v);
            pen_max_v <= collision_pkg::pen_t'(max_v) + ext_h;
        end
    end

endmodule

`default_nettype wire

// ==== sat/box_projector.sv ====
`timescale 1ns/1ps
`default_nettype none

module box_projector (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  collision_pkg::point_t corner0_x, corner0_y,
    input  collision_pkg::point_t corner1_x, corner1_y,
    input  collision_pkg::point_t corner2_x, corner2_y,
    input  collision_pkg::point_t corner3_x, corner3_y,
    input  collision_pkg::pos_t   center_x, center_y,
    input  collision_pkg::axis_t  u_x, u_y,
    input  collision_pkg::axis_t  v_x, v_y,
    output collision_pkg::proj_t  proj_u0, proj_u1, proj_u2, proj_u3,
    output collision_pkg::proj_t  proj_v0, proj_v1, proj_v2, proj_v3
);

    collision_pkg::point_t cx [4];
    collision_pkg::point_t cy [4];
    collision_pkg::point_t dx [4];
    collision_pkg::point_t dy [4];
    collision_pkg::prod_t  dot_u [4];
    collision_pkg::prod_t  dot_v [4];
    collision_pkg::proj_t  pu_q [4];
    collision_pkg::proj_t  pv_q [4];
    collision_pkg::point_t ctr_x;
    collision_pkg::point_t ctr_y;

    assign cx = '{corner0_x, corner1_x, corner2_x, corner3_x};
    assign cy = '{corner0_y, corner1_y, corner2_y, corner3_y};

    // Centre brought down to corner scale
    assign ctr_x = collision_pkg::point_t'(center_x >>> collision_pkg::POS_SHIFT);
    assign ctr_y = collision_pkg::point_t'(center_y >>> collision_pkg::POS_SHIFT);

    // Corners relative to the other box, dotted with its axes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dx[i]    = cx[i] - ctr_x;
            dy[i]    = cy[i] - ctr_y;
            dot_u[i] = dx[i] * u_x + dy[i] * u_y;
            dot_v[i] = dx[i] * v_x + dy[i] * v_y;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                pu_q[i] <= '0;
                pv_q[i] <= '0;
            end
        end else if (load) begin
            for (int i = 0; i < 4; i++) begin
                pu_q[i] <= collision_pkg::proj_t'(dot_u[i] >>> collision_pkg::PROJ_SHIFT);
                pv_q[i] <= collision_pkg::proj_t'(dot_v[i] >>> collision_pkg::PROJ_SHIFT);
            end
        end
    end

    assign proj_u0 = pu_q[0];
    assign proj_u1 = pu_q[1];
    assign proj_u2 = pu_q[2];
    assign proj_u3 = pu_q[3];
    assign proj_v0 = pv_q[0];
    assign proj_v1 = pv_q[1];
    assign proj_v2 = pv_q[2];
    assign proj_v3 = pv_q[3];

endmodule

`default_nettype wire

// ==== rtl/pipe_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic s1_load,
    output logic s2_load,
    output logic s3_load,
    output logic out_valid
);

    logic [collision_pkg::PIPE_DEPTH-1:0] valid_q;

    // One valid bit per stage, shifted along every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[collision_pkg::PIPE_DEPTH-2:0], in_valid};
        end
    end

    // Stage 1 registers take the strobe itself
    assign s1_load   = in_valid;
    assign s2_load   = valid_q[0];
    assign s3_load   = valid_q[1];
    assign out_valid = valid_q[2];

endmodule

`default_nettype wire

// ==== common/collision_pkg.sv ====
`default_nettype none

package collision_pkg;

    // Box centre coordinate
    typedef logic signed [23:0] pos_t;
    // Corner coordinate, a quarter of the centre scale
    typedef logic signed [21:0] point_t;
    // Unit axis component in Q12
    typedef logic signed [15:0] axis_t;
    typedef logic signed [6:0] half_ext_t;
    typedef logic signed [23:0] proj_t;
    // Full width dot product before the Q12 scale is removed
    typedef logic signed [35:0] prod_t;
    // Negative means the boxes are apart on that side of the axis
    typedef logic signed [31:0] pen_t;

    // Centre to corner scale
    localparam int POS_SHIFT = 2;
    // Drops the Q12 axis scale
    localparam int PROJ_SHIFT = 12;
    // Half extent to projection scale
    localparam int EXT_SHIFT = 16;
    // Register stages from in_valid to out_valid
    localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire
